// File: design/cpu_consts.svh
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// datapath width
// one register, one port word, one instruction word
`define CPU_DATA_W 16

// program counter width
// also the width of the instruction address port
`define CPU_ADDR_W 16

// general registers r0..r7
// none of them is hardwired to zero
`define CPU_NREGS 8

// first fetch address after reset
`define CPU_RESET_PC 0

// the register index width follows from CPU_NREGS
// and must match the 3-bit rd/rs/rt fields of the instruction word

`endif

// File: design/cpu_pkg.sv
`include "cpu_consts.svh"

package cpu_pkg;

  typedef logic [`CPU_DATA_W-1:0] data_t;
  typedef logic [`CPU_ADDR_W-1:0] addr_t;
  typedef logic [$clog2(`CPU_NREGS)-1:0] reg_idx_t;

  // instruction word layout
  //   [15:11] opcode
  //   [10:8]  rd
  //   [7:5]   rs
  //   [4:2]   rt
  //   [7:0]   immediate, shares bits with rs and rt
  // shifts take their amount from immediate bits 3..0
  // jmp and jz go to the value held in rs
  typedef enum logic [4:0] {
    op_nop = 5'd0,
    op_add = 5'd1,
    op_sub = 5'd2,
    op_and = 5'd3,
    op_or  = 5'd4,
    op_not = 5'd5,
    op_shl = 5'd6,
    op_shr = 5'd7,
    op_ldi = 5'd8,
    op_mov = 5'd9,
    op_in  = 5'd10,
    op_out = 5'd11,
    op_jmp = 5'd12,
    op_jz  = 5'd13,
    op_hlt = 5'd14
  } opcode_e;

  // fetch to decode
  typedef struct packed {
    logic  valid;
    addr_t pc;
    data_t instr;
  } fetch_reg_t;

  // decode to execute
  typedef struct packed {
    logic       valid;
    opcode_e    op;
    reg_idx_t   rd;
    data_t      op_a;
    data_t      op_b;
    logic [7:0] imm;
  } decode_reg_t;

  // execute to result
  typedef struct packed {
    logic     valid;
    opcode_e  op;
    reg_idx_t rd;
    data_t    result;
    logic     reg_wr;
  } exec_reg_t;

  // register file write, result back to decode
  typedef struct packed {
    logic     we;
    reg_idx_t idx;
    data_t    data;
  } wb_t;

  typedef struct packed {
    logic zero;
    logic neg;
    logic carry;
  } ccr_t;

endpackage

// File: design/instr_fetch.sv
`timescale 1ns/1ps
`include "cpu_consts.svh"

module instr_fetch (
  input  logic                clk,
  input  logic                rst,
  input  cpu_pkg::data_t      imem_data,
  input  logic                redirect,
  input  cpu_pkg::addr_t      redirect_pc,
  input  logic                halt_seen,
  output cpu_pkg::addr_t      imem_addr,
  output cpu_pkg::fetch_reg_t fetch_out,
  output logic                halted
);

  // program counter, presented straight to instruction memory
  cpu_pkg::addr_t pc_q;
  logic           halt_q;
  logic           stop;
  // fetch register
  logic           valid_q;
  cpu_pkg::addr_t fpc_q;
  cpu_pkg::data_t instr_q;

  // halt freezes the pc in the cycle execute sees it
  assign stop = halt_q || halt_seen;

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      pc_q    <= `CPU_ADDR_W'(`CPU_RESET_PC);
      halt_q  <= 1'b0;
      valid_q <= 1'b0;
    end
    else
    begin
      halt_q  <= stop;
      // word fetched now is younger than the jump or halt
      valid_q <= !(stop || redirect);
      if (stop)
        pc_q <= pc_q;
      else if (redirect)
        pc_q <= redirect_pc;
      else
        pc_q <= pc_q + `CPU_ADDR_W'(1);
    end
  end

  // payload, qualified by valid_q
  always_ff @(posedge clk)
  begin
    fpc_q   <= pc_q;
    instr_q <= imem_data;
  end

  assign imem_addr = pc_q;
  assign halted    = halt_q;
  assign fetch_out = '{valid: valid_q, pc: fpc_q, instr: instr_q};

  // once halted, the fetch address never moves again
  a_halt_freezes_pc: assert property (@(posedge clk) disable iff (rst)
    halted |=> $stable(imem_addr));

endmodule

// File: design/instr_decode.sv
`timescale 1ns/1ps
`include "cpu_consts.svh"

module instr_decode (
  input  logic                 clk,
  input  logic                 rst,
  input  cpu_pkg::fetch_reg_t  fetch_in,
  input  logic                 flush,
  input  cpu_pkg::wb_t         wb_in,
  output cpu_pkg::decode_reg_t decode_out
);

  // instruction fields
  cpu_pkg::opcode_e  op;
  cpu_pkg::reg_idx_t rd;
  cpu_pkg::reg_idx_t rs;
  cpu_pkg::reg_idx_t rt;
  logic [7:0]        imm;
  // register file, written by the result stage
  cpu_pkg::data_t    rf [`CPU_NREGS];
  cpu_pkg::data_t    rs_val;
  cpu_pkg::data_t    rt_val;
  // decode register
  logic              valid_q;
  cpu_pkg::opcode_e  op_q;
  cpu_pkg::reg_idx_t rd_q;
  cpu_pkg::data_t    a_q;
  cpu_pkg::data_t    b_q;
  logic [7:0]        imm_q;

  assign op  = cpu_pkg::opcode_e'(fetch_in.instr[15:11]);
  assign rd  = fetch_in.instr[10:8];
  assign rs  = fetch_in.instr[7:5];
  assign rt  = fetch_in.instr[4:2];
  assign imm = fetch_in.instr[7:0];

  // read port with bypass of a write landing this same cycle
  function automatic cpu_pkg::data_t rf_read(cpu_pkg::reg_idx_t idx);
    if (wb_in.we && wb_in.idx == idx)
      return wb_in.data;
    return rf[idx];
  endfunction

  always_comb
  begin
    rs_val = rf_read(rs);
    rt_val = rf_read(rt);
  end

  always_ff @(posedge clk)
  begin
    if (wb_in.we)
      rf[wb_in.idx] <= wb_in.data;
  end

  // flush kills the entry when a jump or halt resolves behind it
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
      valid_q <= 1'b0;
    else
      valid_q <= fetch_in.valid && !flush;
  end

  always_ff @(posedge clk)
  begin
    op_q  <= op;
    rd_q  <= rd;
    a_q   <= rs_val;
    b_q   <= rt_val;
    imm_q <= imm;
  end

  assign decode_out = '{valid: valid_q, op: op_q, rd: rd_q,
                        op_a: a_q, op_b: b_q, imm: imm_q};

  // instruction memory must only hold defined opcodes on the live path
  a_legal_opcode: assert property (@(posedge clk) disable iff (rst)
    fetch_in.valid && !flush |=>
      decode_out.op inside {[cpu_pkg::op_nop:cpu_pkg::op_hlt]});

endmodule

// File: design/alu_execute.sv
`timescale 1ns/1ps
`include "cpu_consts.svh"

module alu_execute (
  input  logic                 clk,
  input  logic                 rst,
  input  cpu_pkg::decode_reg_t decode_in,
  output cpu_pkg::exec_reg_t   exec_out,
  output logic                 redirect,
  output cpu_pkg::addr_t       redirect_pc,
  output logic                 halt_seen
);

  cpu_pkg::data_t    a;
  cpu_pkg::data_t    b;
  // one extra bit on top holds the carry out
  logic [`CPU_DATA_W:0] wide;
  cpu_pkg::data_t    result;
  logic              set_cc;
  logic              reg_wr;
  cpu_pkg::ccr_t     ccr_d;
  cpu_pkg::ccr_t     ccr_q;
  // execute register
  logic              valid_q;
  cpu_pkg::opcode_e  op_q;
  cpu_pkg::reg_idx_t rd_q;
  cpu_pkg::data_t    result_q;
  logic              wr_q;

  assign a = decode_in.op_a;
  assign b = decode_in.op_b;

  // flags move only on arithmetic, logic and shifts
  assign set_cc = decode_in.op inside {cpu_pkg::op_add, cpu_pkg::op_sub,
    cpu_pkg::op_and, cpu_pkg::op_or, cpu_pkg::op_not, cpu_pkg::op_shl, cpu_pkg::op_shr};
  assign reg_wr = set_cc ||
    decode_in.op inside {cpu_pkg::op_ldi, cpu_pkg::op_mov, cpu_pkg::op_in};

  always_comb
  begin
    case (decode_in.op)
      cpu_pkg::op_add: wide = {1'b0, a} + {1'b0, b};
      // borrow shows up as carry
      cpu_pkg::op_sub: wide = {1'b0, a} - {1'b0, b};
      cpu_pkg::op_and: wide = {1'b0, a & b};
      cpu_pkg::op_or:  wide = {1'b0, a | b};
      cpu_pkg::op_not: wide = {1'b0, ~a};
      // last bit shifted out lands in carry
      cpu_pkg::op_shl: wide = {1'b0, a} << decode_in.imm[3:0];
      cpu_pkg::op_shr: wide = {1'b0, a >> decode_in.imm[3:0]};
      cpu_pkg::op_ldi: wide = {{(`CPU_DATA_W - 7){1'b0}}, decode_in.imm};
      // out carries the rs value down to the port
      cpu_pkg::op_mov, cpu_pkg::op_out: wide = {1'b0, a};
      default: wide = '0;
    endcase
  end

  assign result = wide[`CPU_DATA_W-1:0];
  assign ccr_d  = '{zero: (result == '0), neg: result[`CPU_DATA_W-1],
                    carry: wide[`CPU_DATA_W]};

  // jz looks at flags left by older instructions only
  assign redirect    = decode_in.valid && (decode_in.op == cpu_pkg::op_jmp ||
                       (decode_in.op == cpu_pkg::op_jz && ccr_q.zero));
  assign redirect_pc = cpu_pkg::addr_t'(a);
  assign halt_seen   = decode_in.valid && decode_in.op == cpu_pkg::op_hlt;

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      valid_q <= 1'b0;
      ccr_q   <= '0;
    end
    else
    begin
      valid_q <= decode_in.valid;
      if (decode_in.valid && set_cc)
        ccr_q <= ccr_d;
    end
  end

  always_ff @(posedge clk)
  begin
    op_q     <= decode_in.op;
    rd_q     <= decode_in.rd;
    result_q <= result;
    wr_q     <= reg_wr;
  end

  assign exec_out = '{valid: valid_q, op: op_q, rd: rd_q, result: result_q, reg_wr: wr_q};

  // a taken jump leaves nothing live in decode for the next two cycles
  a_redirect_squash: assert property (@(posedge clk) disable iff (rst)
    redirect |=> !decode_in.valid ##1 !decode_in.valid);

endmodule

// File: design/result_stage.sv
`timescale 1ns/1ps

module result_stage (
  input  logic               clk,
  input  logic               rst,
  input  cpu_pkg::exec_reg_t exec_in,
  input  cpu_pkg::data_t     in_port,
  output cpu_pkg::wb_t       wb_out,
  output cpu_pkg::data_t     out_port,
  output logic               out_strobe
);

  logic           is_out;
  cpu_pkg::data_t wb_data;

  assign is_out = exec_in.valid && exec_in.op == cpu_pkg::op_out;

  // in_port is sampled here, not in execute
  assign wb_data = (exec_in.op == cpu_pkg::op_in) ? in_port : exec_in.result;

  // write lands in the register file at the end of this cycle
  assign wb_out = '{we: exec_in.valid && exec_in.reg_wr, idx: exec_in.rd, data: wb_data};

  // port holds its value between out instructions
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      out_port   <= '0;
      out_strobe <= 1'b0;
    end
    else
    begin
      // one pulse per executed out
      out_strobe <= is_out;
      if (is_out)
        out_port <= exec_in.result;
    end
  end

endmodule

// File: design/processor.sv
`timescale 1ns/1ps

module processor (
  input  logic           clk,
  input  logic           rst,
  output cpu_pkg::addr_t imem_addr,
  input  cpu_pkg::data_t imem_data,
  input  cpu_pkg::data_t in_port,
  output cpu_pkg::data_t out_port,
  output logic           out_strobe,
  output logic           halted
);

  cpu_pkg::fetch_reg_t  fetch_reg;
  cpu_pkg::decode_reg_t decode_reg;
  cpu_pkg::exec_reg_t   exec_reg;
  cpu_pkg::wb_t         wb;
  logic                 redirect;
  cpu_pkg::addr_t       redirect_pc;
  logic                 halt_seen;
  logic                 flush;

  // a jump or a halt in execute kills whatever sits in decode
  assign flush = redirect || halt_seen;

  instr_fetch u_fetch (
    .clk         (clk),
    .rst         (rst),
    .imem_data   (imem_data),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .halt_seen   (halt_seen),
    .imem_addr   (imem_addr),
    .fetch_out   (fetch_reg),
    .halted      (halted)
  );

  instr_decode u_decode (
    .clk        (clk),
    .rst        (rst),
    .fetch_in   (fetch_reg),
    .flush      (flush),
    .wb_in      (wb),
    .decode_out (decode_reg)
  );

  alu_execute u_execute (
    .clk         (clk),
    .rst         (rst),
    .decode_in   (decode_reg),
    .exec_out    (exec_reg),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .halt_seen   (halt_seen)
  );

  result_stage u_result (
    .clk        (clk),
    .rst        (rst),
    .exec_in    (exec_reg),
    .in_port    (in_port),
    .wb_out     (wb),
    .out_port   (out_port),
    .out_strobe (out_strobe)
  );

endmodule

// File: test/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
  input  logic restart,
  output logic clk,
  output logic rst
);

  // 10 ns period
  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // rst held for three rising edges, at start and again after each restart pulse
  initial
  begin
    rst = 1'b1;
    forever
    begin
      repeat (3) @(posedge clk);
      rst <= 1'b0;
      @(posedge restart);
      rst <= 1'b1;
    end
  end

endmodule

// File: test/tb_processor.sv
`timescale 1ns/1ps
`include "cpu_consts.svh"

module tb_processor;

  // all-zero word decodes as nop
  localparam cpu_pkg::data_t nop_word = '0;

  logic           clk;
  logic           rst;
  logic           restart;
  cpu_pkg::addr_t imem_addr;
  cpu_pkg::data_t imem_data;
  cpu_pkg::data_t in_port;
  cpu_pkg::data_t out_port;
  logic           out_strobe;
  logic           halted;

  // program image, read without a clock
  cpu_pkg::data_t imem [64];
  cpu_pkg::data_t prog [$];
  cpu_pkg::data_t exp_q [$];
  logic [31:0]    lfsr_state;
  // cycle budget, grows by 20 per loaded program word
  int             limit = 40;
  int             cycles;
  int             data_errs = 0;
  int             count_errs = 0;
  int             other_errs = 0;

  tb_clock clk_gen (.restart(restart), .clk(clk), .rst(rst));

  processor dut0 (
    .clk        (clk),
    .rst        (rst),
    .imem_addr  (imem_addr),
    .imem_data  (imem_data),
    .in_port    (in_port),
    .out_port   (out_port),
    .out_strobe (out_strobe),
    .halted     (halted)
  );

  assign imem_data = imem[imem_addr[5:0]];

  // taps 32 22 2 1, one step per bit taken
  function automatic logic [`CPU_DATA_W-1:0] rand_bits(int n);
    logic [`CPU_DATA_W-1:0] v;
    logic                   fb;
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      v          = {v[`CPU_DATA_W-2:0], fb};
    end
    return v;
  endfunction

  // register form, opcode rd rs rt
  function automatic cpu_pkg::data_t encode(cpu_pkg::opcode_e op, int rd, int rs, int rt);
    return {op, 3'(rd), 3'(rs), 3'(rt), 2'b00};
  endfunction

  // immediate form; shifts put rs in the top three immediate bits
  function automatic cpu_pkg::data_t encode_imm(cpu_pkg::opcode_e op, int rd, logic [7:0] imm);
    return {op, 3'(rd), imm};
  endfunction

  task automatic check_data(string name, cpu_pkg::data_t got, cpu_pkg::data_t exp);
    if (got !== exp)
    begin
      $display("error %s: got 0x%h, expected 0x%h", name, got, exp);
      data_errs++;
    end
  endtask

  task automatic check_count(string name, int got, int exp);
    if (got != exp)
    begin
      $display("error %s out_strobe count: got 0x%h, expected 0x%h", name, got, exp);
      count_errs++;
    end
  endtask

  // reset, load, collect port writes up to halt, compare
  task automatic run_program(string name);
    cpu_pkg::data_t outs [$];
    @(posedge clk);
    restart <= 1'b1;
    @(posedge clk);
    restart <= 1'b0;
    // load while the core sits in reset
    @(negedge clk);
    foreach (imem[i])
      imem[i] = (i < prog.size()) ? prog[i] : nop_word;
    limit += 20 * prog.size();
    do
      @(negedge clk);
    while (rst);
    if (halted || out_strobe)
    begin
      $display("%s: halted or out_strobe set right after reset", name);
      other_errs++;
    end
    check_data({name, " out_port"}, out_port, '0);
    check_data({name, " imem_addr"}, imem_addr, `CPU_ADDR_W'(`CPU_RESET_PC));
    while (!halted)
    begin
      @(negedge clk);
      if (out_strobe)
        outs.push_back(out_port);
    end
    // nothing younger than the halt may reach the port
    repeat (6)
    begin
      @(negedge clk);
      if (out_strobe)
      begin
        $display("%s: out_strobe pulsed after halt", name);
        other_errs++;
      end
    end
    check_count(name, outs.size(), exp_q.size());
    foreach (exp_q[i])
      if (i < outs.size())
        check_data($sformatf("%s out_port[%0d]", name, i), outs[i], exp_q[i]);
    prog.delete();
    exp_q.delete();
  endtask

  task automatic test_ldi();
    logic [7:0] imm [4];
    for (int i = 0; i < 4; i++)
    begin
      imm[i] = 8'(rand_bits(8));
      prog.push_back(encode_imm(cpu_pkg::op_ldi, i, imm[i]));
    end
    // first out lands four slots after its ldi
    for (int i = 0; i < 4; i++)
    begin
      prog.push_back(encode(cpu_pkg::op_out, 0, i, 0));
      exp_q.push_back({8'h00, imm[i]});
    end
    prog.push_back(encode(cpu_pkg::op_hlt, 0, 0, 0));
    run_program("ldi");
  endtask

  task automatic test_alu();
    logic [7:0]     a_hi;
    logic [7:0]     a_lo;
    logic [7:0]     b_hi;
    logic [7:0]     b_lo;
    logic [3:0]     sh_l;
    logic [3:0]     sh_r;
    cpu_pkg::data_t a;
    cpu_pkg::data_t b;
    a_hi = 8'(rand_bits(8));
    a_lo = 8'(rand_bits(8));
    b_hi = 8'(rand_bits(8));
    b_lo = 8'(rand_bits(8));
    sh_l = 4'(rand_bits(4));
    sh_r = 4'(rand_bits(4));
    a    = {a_hi, a_lo};
    b    = {b_hi, b_lo};
    // r1 = a, r3 = b, each built from two bytes
    prog.push_back(encode_imm(cpu_pkg::op_ldi, 1, a_hi));
    prog.push_back(encode_imm(cpu_pkg::op_ldi, 2, a_lo));
    prog.push_back(encode_imm(cpu_pkg::op_ldi, 3, b_hi));
    prog.push_back(encode_imm(cpu_pkg::op_shl, 1, {3'd1, 5'd8}));
    prog.push_back(encode_imm(cpu_pkg::op_ldi, 4, b_lo));
    prog.push_back(encode_imm(cpu_pkg::op_shl, 3, {3'd3, 5'd8}));
    prog.push_back(encode(cpu_pkg::op_or, 1, 1, 2));
    prog.push_back(nop_word);
    prog.push_back(encode(cpu_pkg::op_or, 3, 3, 4));
    prog.push_back(nop_word);
    prog.push_back(nop_word);
    // three results in flight, each read back three slots later
    prog.push_back(encode(cpu_pkg::op_add, 5, 1, 3));
    prog.push_back(encode(cpu_pkg::op_sub, 6, 1, 3));
    prog.push_back(encode(cpu_pkg::op_and, 7, 1, 3));
    prog.push_back(encode(cpu_pkg::op_out, 0, 5, 0));
    prog.push_back(encode(cpu_pkg::op_out, 0, 6, 0));
    prog.push_back(encode(cpu_pkg::op_out, 0, 7, 0));
    prog.push_back(encode(cpu_pkg::op_or, 5, 1, 3));
    prog.push_back(encode(cpu_pkg::op_not, 6, 1, 0));
    prog.push_back(encode_imm(cpu_pkg::op_shl, 7, {3'd1, 1'b0, sh_l}));
    prog.push_back(encode(cpu_pkg::op_out, 0, 5, 0));
    prog.push_back(encode(cpu_pkg::op_out, 0, 6, 0));
    prog.push_back(encode(cpu_pkg::op_out, 0, 7, 0));
    prog.push_back(encode_imm(cpu_pkg::op_shr, 5, {3'd1, 1'b0, sh_r}));
    prog.push_back(nop_word);
    prog.push_back(nop_word);
    prog.push_back(encode(cpu_pkg::op_out, 0, 5, 0));
    prog.push_back(encode(cpu_pkg::op_hlt, 0, 0, 0));
    // 16-bit results wrap
    exp_q.push_back(a + b);
    exp_q.push_back(a - b);
    exp_q.push_back(a & b);
    exp_q.push_back(a | b);
    exp_q.push_back(~a);
    exp_q.push_back(a << sh_l);
    exp_q.push_back(a >> sh_r);
    run_program("alu");
  endtask

  task automatic test_in();
    cpu_pkg::data_t v;
    v = rand_bits(16);
    // port level set before the program starts
    @(posedge clk);
    in_port <= v;
    prog.push_back(encode(cpu_pkg::op_in, 2, 0, 0));
    prog.push_back(nop_word);
    prog.push_back(nop_word);
    prog.push_back(encode(cpu_pkg::op_out, 0, 2, 0));
    prog.push_back(encode(cpu_pkg::op_hlt, 0, 0, 0));
    exp_q.push_back(v);
    run_program("in");
  endtask

  task automatic test_jump();
    prog.push_back(encode_imm(cpu_pkg::op_ldi, 1, 8'd8));
    prog.push_back(encode_imm(cpu_pkg::op_ldi, 2, 8'd14));
    prog.push_back(encode_imm(cpu_pkg::op_ldi, 3, 8'h55));
    prog.push_back(encode_imm(cpu_pkg::op_ldi, 4, 8'h66));
    prog.push_back(encode(cpu_pkg::op_jmp, 0, 1, 0));
    // slots 5 and 6 squashed, 7 never fetched
    prog.push_back(encode(cpu_pkg::op_out, 0, 3, 0));
    prog.push_back(encode(cpu_pkg::op_out, 0, 4, 0));
    prog.push_back(encode(cpu_pkg::op_out, 0, 3, 0));
    prog.push_back(encode(cpu_pkg::op_out, 0, 4, 0));
    // zero result sets the flag for the next jz
    prog.push_back(encode(cpu_pkg::op_sub, 5, 3, 3));
    prog.push_back(encode(cpu_pkg::op_jz, 0, 2, 0));
    prog.push_back(encode(cpu_pkg::op_out, 0, 3, 0));
    prog.push_back(encode(cpu_pkg::op_out, 0, 4, 0));
    prog.push_back(encode(cpu_pkg::op_out, 0, 3, 0));
    prog.push_back(encode(cpu_pkg::op_or, 6, 3, 4));
    // flag now clear, falls through
    prog.push_back(encode(cpu_pkg::op_jz, 0, 1, 0));
    prog.push_back(encode(cpu_pkg::op_out, 0, 3, 0));
    prog.push_back(encode(cpu_pkg::op_out, 0, 6, 0));
    prog.push_back(encode(cpu_pkg::op_hlt, 0, 0, 0));
    prog.push_back(encode(cpu_pkg::op_out, 0, 4, 0));
    exp_q.push_back(16'h0066);
    exp_q.push_back(16'h0055);
    exp_q.push_back(16'h0077);
    run_program("jump");
  endtask

  task automatic test_halt();
    logic [7:0] x;
    logic [7:0] y;
    x = 8'(rand_bits(8));
    y = 8'(rand_bits(8));
    prog.push_back(encode_imm(cpu_pkg::op_ldi, 1, x));
    prog.push_back(encode_imm(cpu_pkg::op_ldi, 2, y));
    prog.push_back(nop_word);
    prog.push_back(encode(cpu_pkg::op_out, 0, 1, 0));
    prog.push_back(encode(cpu_pkg::op_out, 0, 2, 0));
    prog.push_back(encode(cpu_pkg::op_hlt, 0, 0, 0));
    // younger outs, all must be dropped
    prog.push_back(encode(cpu_pkg::op_out, 0, 1, 0));
    prog.push_back(encode(cpu_pkg::op_out, 0, 2, 0));
    prog.push_back(encode(cpu_pkg::op_out, 0, 1, 0));
    exp_q.push_back({8'h00, x});
    exp_q.push_back({8'h00, y});
    run_program("halt");
    check_data("halt out_port held", out_port, {8'h00, y});
  endtask

  initial
  begin
    cycles = 0;
    while (cycles <= limit)
    begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout: %0d cycles passed without reaching halt", cycles);
    $display("test failed");
    $finish;
  end

  initial
  begin
    restart    = 1'b0;
    in_port    = '0;
    lfsr_state = 32'ha975;
    foreach (imem[i])
      imem[i] = nop_word;
    @(negedge rst);
    test_ldi();
    test_alu();
    test_in();
    test_jump();
    test_halt();
    $display("errors: data %0d, count %0d, other %0d", data_errs, count_errs, other_errs);
    if (data_errs + count_errs + other_errs == 0)
      $display("test passed");
    else
      $display("test failed");
    $finish;
  end

endmodule

// File: project.f
+incdir+design
design/cpu_pkg.sv
design/instr_fetch.sv
design/instr_decode.sv
design/alu_execute.sv
design/result_stage.sv
design/processor.sv
test/tb_clock.sv
test/tb_processor.sv

// File: run.sh
#!/bin/sh
# build the simulation with Verilator, run it, look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f project.f --top-module tb_processor \
  --Mdir obj_dir -o sim_processor
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/sim_processor)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "test passed"; then
  exit 0
fi
exit 1
